// File: verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Datapath widths of the fetch front end
    localparam int PC_W    = 32;
    localparam int INSTR_W = 32;

    // First fetch address after reset
    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_0000;

    // PC queue geometry
    // Depth must stay a power of two so the pointers wrap on their own
    localparam int PCQ_DEPTH = 4;
    localparam int PCQ_PTR_W = $clog2(PCQ_DEPTH);
    localparam int PCQ_CNT_W = 3;                 // Counts 0 to PCQ_DEPTH

    // The drain counter may have to cover stale requests of a redirect
    // that lands while an earlier drain is still running, so it gets one
    // more bit than the queue occupancy
    localparam int DRAIN_CNT_W = PCQ_CNT_W + 1;

    // Second fetch stage state
    typedef enum logic {
        F2_RUN   = 1'b0,                          // Pair responses with queued PCs
        F2_DRAIN = 1'b1                           // Throw away responses from before a redirect
    } fetch2_state_e;

endpackage

`default_nettype wire

// File: verilog/pc_gen.sv
`default_nettype none

// First fetch stage
// Holds the fetch PC and sends one request strobe per cycle at most. The
// request address doubles as the push value of the PC queue, so the queue
// always knows which PC each outstanding response belongs to.
module pc_gen import fetch_pkg::*; (
    input  wire             clk_i,
    input  wire             rstn_i,

    input  wire             redirect_i,
    input  wire  [PC_W-1:0] redirect_pc_i,

    input  wire             pcq_full_i,

    output logic            imem_req_o,
    output logic [PC_W-1:0] imem_addr_o
);

    logic [PC_W-1:0] pc_r;
    logic            fetch_en_r;
    logic            req;

    // Nothing is requested in a redirect cycle, the PC is reloaded instead
    // and the target goes out in the following cycle
    assign req = fetch_en_r && !pcq_full_i && !redirect_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_r       <= RESET_PC;
            fetch_en_r <= 1'b0;                   // Requests start one cycle after reset releases
        end else begin
            fetch_en_r <= 1'b1;
            if (redirect_i) begin
                pc_r <= redirect_pc_i;
            end else if (req) begin
                pc_r <= pc_r + PC_W'(4);          // Sequential fetch, no compressed instructions
            end
        end
    end

    assign imem_req_o  = req;
    assign imem_addr_o = pc_r;

endmodule

`default_nettype wire

// File: verilog/pc_queue.sv
`default_nettype none

// In-order queue of the PCs whose instructions are still in flight
// The head entry is the PC of the oldest outstanding request.
module pc_queue import fetch_pkg::*; (
    input  wire                  clk_i,
    input  wire                  rstn_i,

    input  wire                  clear_i,

    input  wire                  push_i,
    input  wire  [PC_W-1:0]      push_pc_i,

    input  wire                  pop_i,
    output logic [PC_W-1:0]      head_pc_o,

    output logic [PCQ_CNT_W-1:0] count_o,
    output logic                 empty_o,
    output logic                 full_o
);

    logic [PC_W-1:0]      pc_mem [PCQ_DEPTH];
    logic [PCQ_PTR_W-1:0] wr_ptr_r;
    logic [PCQ_PTR_W-1:0] rd_ptr_r;
    logic [PCQ_CNT_W-1:0] count_r;

    // Entries are written at the write pointer on a push
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_r] <= push_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || clear_i) begin
            wr_ptr_r <= '0;                       // A clear beats any push or pop
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_r <= wr_ptr_r + PCQ_PTR_W'(1);
            end
            if (pop_i) begin
                rd_ptr_r <= rd_ptr_r + PCQ_PTR_W'(1);
            end
            case ({push_i, pop_i})
                2'b10:   count_r <= count_r + PCQ_CNT_W'(1);
                2'b01:   count_r <= count_r - PCQ_CNT_W'(1);
                default: count_r <= count_r;      // Both or neither leave occupancy as is
            endcase
        end
    end

    assign head_pc_o = pc_mem[rd_ptr_r];
    assign count_o   = count_r;
    assign empty_o   = (count_r == '0);
    assign full_o    = (count_r == PCQ_CNT_W'(PCQ_DEPTH));

    // The generator must hold off while the queue is full
    a_no_push_when_full : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        push_i && full_o |-> clear_i
    ) else $error("PC queue pushed while full");

    // The second stage only pops for a response it could pair with a PC
    a_no_pop_when_empty : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        pop_i |-> !empty_o
    ) else $error("PC queue popped while empty");

endmodule

`default_nettype wire

// File: verilog/fetch2.sv
`default_nettype none

// Second fetch stage
// Takes memory responses in order, pairs each with the PC at the head of
// the PC queue and loads the pair into the decode register. After a
// redirect the responses of older requests still arrive and are dropped
// here, one per count of the drain counter.
module fetch2 import fetch_pkg::*; (
    input  wire                  clk_i,
    input  wire                  rstn_i,

    input  wire                  redirect_i,

    input  wire                  imem_rsp_valid_i,
    input  wire  [INSTR_W-1:0]   imem_rsp_data_i,
    output logic                 imem_rsp_ready_o,

    input  wire  [PC_W-1:0]      pcq_head_pc_i,
    input  wire  [PCQ_CNT_W-1:0] pcq_count_i,
    input  wire                  pcq_empty_i,
    output logic                 pcq_pop_o,

    input  wire                  dec_stall_i,
    output logic                 dec_valid_o,
    output logic [INSTR_W-1:0]   dec_instr_o,
    output logic [PC_W-1:0]      dec_pc_o
);

    fetch2_state_e          state_r;
    fetch2_state_e          state_ns;

    logic [DRAIN_CNT_W-1:0] drain_cnt_r;
    logic [DRAIN_CNT_W-1:0] drain_cnt_ns;
    logic [DRAIN_CNT_W-1:0] stale_cnt;

    logic                   dec_valid_r;
    logic                   dec_valid_ns;
    logic [INSTR_W-1:0]     dec_instr_r;
    logic [INSTR_W-1:0]     dec_instr_ns;
    logic [PC_W-1:0]        dec_pc_r;
    logic [PC_W-1:0]        dec_pc_ns;

    logic                   rsp_ready;
    logic                   rsp_fire;

    // Response ready
    // Under a stall the decode register is full and the memory must hold
    always_comb begin
        if (state_r == F2_DRAIN) begin
            rsp_ready = 1'b1;                     // Stale responses are always swallowed
        end else if (redirect_i) begin
            rsp_ready = (pcq_count_i != '0);      // Decode register is dropped anyway
        end else begin
            rsp_ready = !pcq_empty_i && (!dec_valid_r || !dec_stall_i);
        end
    end

    assign rsp_fire  = imem_rsp_valid_i && rsp_ready;
    assign pcq_pop_o = rsp_fire && (state_r == F2_RUN);

    // Requests older than a redirect that still owe a response. In F2_RUN
    // the drain counter is zero, in F2_DRAIN it adds the earlier leftovers
    assign stale_cnt = drain_cnt_r
                     + DRAIN_CNT_W'(pcq_count_i)
                     - DRAIN_CNT_W'(rsp_fire);

    always_comb begin
        state_ns     = state_r;
        drain_cnt_ns = drain_cnt_r;
        dec_valid_ns = dec_valid_r;
        dec_instr_ns = dec_instr_r;
        dec_pc_ns    = dec_pc_r;

        if (redirect_i) begin
            dec_valid_ns = 1'b0;
            drain_cnt_ns = stale_cnt;
            state_ns     = (stale_cnt != '0) ? F2_DRAIN : F2_RUN;
        end else begin
            case (state_r)
                F2_RUN: begin
                    if (rsp_fire) begin
                        dec_valid_ns = 1'b1;
                        dec_instr_ns = imem_rsp_data_i;
                        dec_pc_ns    = pcq_head_pc_i;   // Oldest PC belongs to this response
                    end else if (!dec_stall_i) begin
                        dec_valid_ns = 1'b0;            // Decode took it and nothing new came in
                    end
                end
                F2_DRAIN: begin
                    // The queue now holds only post-redirect PCs and is left alone
                    if (rsp_fire) begin
                        drain_cnt_ns = drain_cnt_r - DRAIN_CNT_W'(1);
                        if (drain_cnt_r == DRAIN_CNT_W'(1)) begin
                            state_ns = F2_RUN;
                        end
                    end
                end
                default: begin
                    state_ns = F2_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r     <= F2_RUN;
            drain_cnt_r <= '0;
            dec_valid_r <= 1'b0;
        end else begin
            state_r     <= state_ns;
            drain_cnt_r <= drain_cnt_ns;
            dec_valid_r <= dec_valid_ns;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_instr_r <= dec_instr_ns;
        dec_pc_r    <= dec_pc_ns;
    end

    assign imem_rsp_ready_o = rsp_ready;
    assign dec_valid_o      = dec_valid_r;
    assign dec_instr_o      = dec_instr_r;
    assign dec_pc_o         = dec_pc_r;

    // A stale response must always have a count left to consume
    a_drain_not_at_zero : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        state_r == F2_DRAIN && rsp_fire |-> drain_cnt_r != '0
    ) else $error("Drain counter decremented at zero");

    // Pairing needs a queued PC for every response taken in F2_RUN
    a_run_fire_has_pc : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        state_r == F2_RUN && rsp_fire |-> !pcq_empty_i
    ) else $error("Response accepted with an empty PC queue");

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`default_nettype none

// Instruction fetch front end
// The PC generator feeds the PC queue and the memory with the same address,
// the second stage pops the queue as responses come back.
module fetch_top import fetch_pkg::*; (
    input  wire                clk_i,
    input  wire                rstn_i,

    // Redirect from a later stage
    input  wire                redirect_i,
    input  wire  [PC_W-1:0]    redirect_pc_i,

    // Instruction memory request and response
    output logic               imem_req_o,
    output logic [PC_W-1:0]    imem_addr_o,
    input  wire                imem_rsp_valid_i,
    input  wire  [INSTR_W-1:0] imem_rsp_data_i,
    output logic               imem_rsp_ready_o,

    // Decode side
    input  wire                dec_stall_i,
    output logic               dec_valid_o,
    output logic [INSTR_W-1:0] dec_instr_o,
    output logic [PC_W-1:0]    dec_pc_o
);

    logic                 pcq_full;
    logic                 pcq_empty;
    logic                 pcq_pop;
    logic [PC_W-1:0]      pcq_head_pc;
    logic [PCQ_CNT_W-1:0] pcq_count;

    pc_gen pc_gen_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pcq_full_i    (pcq_full),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o)
    );

    // Every request strobe is a push of its address
    pc_queue pc_queue_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .clear_i   (redirect_i),
        .push_i    (imem_req_o),
        .push_pc_i (imem_addr_o),
        .pop_i     (pcq_pop),
        .head_pc_o (pcq_head_pc),
        .count_o   (pcq_count),
        .empty_o   (pcq_empty),
        .full_o    (pcq_full)
    );

    fetch2 fetch2_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_i       (redirect_i),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .imem_rsp_ready_o (imem_rsp_ready_o),
        .pcq_head_pc_i    (pcq_head_pc),
        .pcq_count_i      (pcq_count),
        .pcq_empty_i      (pcq_empty),
        .pcq_pop_o        (pcq_pop),
        .dec_stall_i      (dec_stall_i),
        .dec_valid_o      (dec_valid_o),
        .dec_instr_o      (dec_instr_o),
        .dec_pc_o         (dec_pc_o)
    );

endmodule

`default_nettype wire

// File: test/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // The memory image fills the first words of the data file, the
    // redirect records follow in pairs of count and target
    localparam int          MEM_WORDS  = 64;
    localparam int          DATA_WORDS = 128;
    localparam logic [31:0] END_MARK   = 32'hFFFF_FFFF;

    logic               clk_i;
    logic               rstn_i;
    logic               redirect_i;
    logic [PC_W-1:0]    redirect_pc_i;
    logic               imem_req_o;
    logic [PC_W-1:0]    imem_addr_o;
    logic               imem_rsp_valid_i;
    logic [INSTR_W-1:0] imem_rsp_data_i;
    logic               imem_rsp_ready_o;
    logic               dec_stall_i;
    logic               dec_valid_o;
    logic [INSTR_W-1:0] dec_instr_o;
    logic [PC_W-1:0]    dec_pc_o;

    logic [31:0]        testdata [DATA_WORDS];
    logic [INSTR_W-1:0] imem [MEM_WORDS];
    int                 rec_cnt[$];
    logic [PC_W-1:0]    rec_tgt[$];

    logic [PC_W-1:0]    addr_q[$];                // Requests the memory still owes a response for
    int                 due_q[$];                 // First cycle each response may be shown

    integer             seed = 16723;
    int                 cycle;
    int                 limit;
    int                 total;
    int                 delivered;
    int                 seg_cnt;                  // Deliveries since the last redirect
    int                 rec_idx;
    logic [PC_W-1:0]    exp_pc;
    logic [PC_W-1:0]    req_pc;                   // Address the next request must carry
    logic               done;

    logic               held;

    fetch_top fetch_top_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .imem_req_o       (imem_req_o),
        .imem_addr_o      (imem_addr_o),
        .imem_rsp_valid_i (imem_rsp_valid_i),
        .imem_rsp_data_i  (imem_rsp_data_i),
        .imem_rsp_ready_o (imem_rsp_ready_o),
        .dec_stall_i      (dec_stall_i),
        .dec_valid_o      (dec_valid_o),
        .dec_instr_o      (dec_instr_o),
        .dec_pc_o         (dec_pc_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pc(input string name, input logic [PC_W-1:0] got,
                            input logic [PC_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input logic [INSTR_W-1:0] got,
                               input logic [INSTR_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic load_testdata();
        int   i;
        logic found_end;
        for (i = 0; i < DATA_WORDS; i++) begin
            testdata[i] = END_MARK;
        end
        $readmemh("test/fetch_testdata.txt", testdata);
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = testdata[i];
        end
        // Records run until one whose target is the end mark
        total     = 0;
        found_end = 1'b0;
        i         = MEM_WORDS;
        while (!found_end && i + 1 < DATA_WORDS) begin
            if (testdata[i] == END_MARK || testdata[i] == 0) begin
                stop_run("Test data holds a redirect record without a valid count");
            end
            rec_cnt.push_back(int'(testdata[i]));
            rec_tgt.push_back(testdata[i + 1]);
            total     += int'(testdata[i]);
            found_end  = (testdata[i + 1] == END_MARK);
            i         += 2;
        end
        if (!found_end) begin
            stop_run("Test data has no closing redirect record");
        end
    endtask

    // A stalled instruction must still sit on the decode outputs
    task automatic check_hold();
        if (held) begin
            check_flag("dec_valid_o", dec_valid_o, 1'b1);
            check_pc("dec_pc_o", dec_pc_o, exp_pc);
            check_instr("dec_instr_o", dec_instr_o, imem[exp_pc[7:2]]);
        end
    endtask

    task automatic drive_inputs();
        logic            stall;
        logic [PC_W-1:0] head;
        stall       = ($random(seed) & 7) < 3;
        dec_stall_i = stall;

        // The oldest owed response shows once its latency has passed and
        // stays until the DUT takes it
        if (addr_q.size() > 0 && cycle >= due_q[0]) begin
            head             = addr_q[0];
            imem_rsp_valid_i = 1'b1;
            imem_rsp_data_i  = imem[head[7:2]];
        end else begin
            imem_rsp_valid_i = 1'b0;
            imem_rsp_data_i  = '0;
        end

        if (dec_valid_o && !stall && seg_cnt + 1 == rec_cnt[rec_idx]
                && rec_tgt[rec_idx] != END_MARK) begin
            redirect_i    = 1'b1;                 // Fires with the delivery that ends the record
            redirect_pc_i = rec_tgt[rec_idx];
        end else begin
            redirect_i    = 1'b0;
            redirect_pc_i = '0;
        end
    endtask

    // Sampled mid-cycle, this is what the coming rising edge will do
    task automatic observe_cycle();
        int lat;
        if (imem_rsp_valid_i && imem_rsp_ready_o) begin
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
        end

        if (cycle == 1) begin
            check_flag("imem_req_o", imem_req_o, 1'b1);   // Fetch starts right after reset
        end
        if (redirect_i) begin
            check_flag("imem_req_o", imem_req_o, 1'b0);
        end
        if (imem_req_o) begin
            check_pc("imem_addr_o", imem_addr_o, req_pc);
            lat = 1 + int'($unsigned($random(seed)) % 3);
            addr_q.push_back(imem_addr_o);
            due_q.push_back(cycle + lat);
            req_pc = req_pc + PC_W'(4);
        end else if (redirect_i) begin
            req_pc = redirect_pc_i;               // The target is the next address requested
        end

        held = dec_valid_o && dec_stall_i;

        if (dec_valid_o && !dec_stall_i) begin
            check_pc("dec_pc_o", dec_pc_o, exp_pc);
            check_instr("dec_instr_o", dec_instr_o, imem[exp_pc[7:2]]);
            delivered++;
            seg_cnt++;
            exp_pc = exp_pc + PC_W'(4);
            if (seg_cnt == rec_cnt[rec_idx]) begin
                if (rec_tgt[rec_idx] == END_MARK) begin
                    done = 1'b1;
                end else begin
                    exp_pc  = rec_tgt[rec_idx];   // Nothing fetched before the redirect may follow
                    seg_cnt = 0;
                    rec_idx++;
                end
            end
        end
    endtask

    initial begin
        rstn_i           = 1'b0;
        redirect_i       = 1'b0;
        redirect_pc_i    = '0;
        imem_rsp_valid_i = 1'b0;
        imem_rsp_data_i  = '0;
        dec_stall_i      = 1'b0;
        cycle            = 0;
        delivered        = 0;
        seg_cnt          = 0;
        rec_idx          = 0;
        exp_pc           = RESET_PC;
        req_pc           = RESET_PC;
        done             = 1'b0;
        held             = 1'b0;

        load_testdata();
        limit = 12 * total + 100;

        repeat (2) @(posedge clk_i);
        #2;
        // Reset leaves the front end idle
        check_flag("imem_req_o", imem_req_o, 1'b0);
        check_flag("imem_rsp_ready_o", imem_rsp_ready_o, 1'b0);
        check_flag("dec_valid_o", dec_valid_o, 1'b0);
        rstn_i = 1'b1;

        while (!done) begin
            @(posedge clk_i);
            #2;
            cycle++;
            if (cycle > limit) begin
                stop_run($sformatf("Run timed out after %0d cycles, %0d of %0d delivered",
                                   cycle, delivered, total));
            end
            check_hold();
            drive_inputs();
            @(negedge clk_i);
            observe_cycle();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/fetch_testdata.txt
// Words 0 to 63: instruction memory, eight per line, indexed by PC bits 7 to 2
// Then redirect records: delivered count, target PC (target FFFFFFFF ends the run)
00000013 00100093 00200113 00300193 00400213 00500293 00600313 00700393
00800413 00900493 00A00513 00B00593 00C00613 00D00693 00E00713 00F00793
01000813 01100893 01200913 01300993 01400A13 01500A93 01600B13 01700B93
01800C13 01900C93 01A00D13 01B00D93 01C00E13 01D00E93 01E00F13 01F00F93
02000013 02100093 02200113 02300193 02400213 02500293 02600313 02700393
02800413 02900493 02A00513 02B00593 02C00613 02D00693 02E00713 02F00793
03000813 03100893 03200913 03300993 03400A13 03500A93 03600B13 03700B93
03800C13 03900C93 03A00D13 03B00D93 03C00E13 03D00E93 03E00F13 03F00F93
// Redirect records
00000008 00000080
00000005 00000010
00000001 000000C0
00000001 00000024
00000006 000000F0
00000006 00000040
00000001 00000044
0000000C FFFFFFFF

// File: vlog.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/pc_queue.sv
verilog/fetch2.sv
verilog/fetch_top.sv
test/tb_fetch_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator from the project root

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch_top -f vlog.f -o tb_fetch_top > build.log 2>&1 \
    && ./obj_dir/tb_fetch_top > sim.log 2>&1 \
    && grep -q "^TEST OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
